// ==== verilog.f ====
fmrt_pkg.sv
spm.sv
axil_host_port.sv
if_stage.sv
id_stage.sv
gpr.sv
ex_stage.sv
mem_stage.sv
fmrt_core_top.sv
tb_fmrt_core.sv

// ==== Makefile ====
SIM := obj_dir/Vtb_fmrt_core

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): verilog.f *.sv
	verilator --binary --timing --assert --top-module tb_fmrt_core -f verilog.f

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Some tests failed" sim.log || ! grep -q "All tests passed" sim.log; then \
		echo "Simulation FAILED"; \
		exit 1; \
	fi
	@echo "Simulation PASSED"

clean:
	rm -rf obj_dir sim.log

// ==== tb_fmrt_core.sv ====
`timescale 1ns/100ps

module tb_fmrt_core;
    import fmrt_pkg::*;

    localparam logic [1:0] OKAY           = 2'b00;
    localparam logic [1:0] SLVERR         = 2'b10;
    localparam int         PROG_LEN       = 23;          // Instructions per hart
    localparam int         TIMEOUT_CYCLES = PROG_LEN * NUM_HARTS * NUM_HARTS * 4 + 2000;
    localparam op_e        ALU_OPS [6]    = '{OP_ADDI, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};

    typedef struct packed {
        reg_addr_t rd;
        word_t     data;
    } exp_wb_t;

    logic        i_clk, i_arst_n;
    logic [15:0] i_awaddr, i_araddr;
    logic        i_awvalid, i_wvalid, i_bready, i_arvalid, i_rready;
    word_t       i_wdata, o_rdata;
    logic        o_awready, o_wready, o_bvalid, o_arready, o_rvalid, o_all_idle;
    logic [1:0]  o_bresp, o_rresp;
    wb_t         o_wb;

    word_t       lfsr_state = 32'd10;                    // Fixed seed
    word_t       model_regs [NUM_HARTS][NUM_REGS];       // Reference GPR banks
    word_t       model_mem [SPM_WORDS];
    word_t       prog [SPM_WORDS];
    int          pc_cnt [NUM_HARTS];
    exp_wb_t     exp_q [NUM_HARTS][$];                   // Pending write-backs per hart
    int          checks = 0;
    int          errors = 0;

    fmrt_core_top dut_i (.*);

    initial begin : clock_gen
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;                       // 8 ns period
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge i_clk);
        $display("Timeout after %0d cycles, the run did not complete", TIMEOUT_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    // Galois LFSR, one step per bit
    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    ////////////////////
    // RV32I encoders
    ////////////////////
    function automatic word_t itype(input logic [11:0] imm, input int rs1, input logic [2:0] f3,
                                    input int rd, input logic [6:0] opc);
        return {imm, rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic word_t rtype(input logic [6:0] f7, input int rs2, input int rs1,
                                    input logic [2:0] f3, input int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
    endfunction

    function automatic word_t stype(input logic [11:0] imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    // Append one instruction and step the hart's model
    task automatic put_insn(input int h, input op_e op, input int rd, input int rs1,
                            input int rs2, input word_t imm_bits);
        word_t   a, b, imm, ea, res, insn;
        exp_wb_t e;
        a   = model_regs[h][rs1];
        b   = model_regs[h][rs2];
        imm = {{20{imm_bits[11]}}, imm_bits[11:0]};      // Sign-extended 12 bits
        ea  = a + imm;
        case (op)
            OP_ADDI: res = a + imm;
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_LW:   res = model_mem[ea[11:2]];
            default: res = '0;
        endcase
        case (op)
            OP_ADDI: insn = itype(imm[11:0], rs1, 3'b000, rd, 7'b0010011);
            OP_ADD:  insn = rtype(7'h00, rs2, rs1, 3'b000, rd);
            OP_SUB:  insn = rtype(7'h20, rs2, rs1, 3'b000, rd);
            OP_AND:  insn = rtype(7'h00, rs2, rs1, 3'b111, rd);
            OP_OR:   insn = rtype(7'h00, rs2, rs1, 3'b110, rd);
            OP_XOR:  insn = rtype(7'h00, rs2, rs1, 3'b100, rd);
            OP_LW:   insn = itype(imm[11:0], rs1, 3'b010, rd, 7'b0000011);
            OP_SW:   insn = stype(imm[11:0], rs2, rs1);
            default: insn = 32'h0000_0073;               // ECALL
        endcase
        if (op == OP_SW)
            model_mem[ea[11:2]] = b;
        prog[h * HART_CODE_WORDS + pc_cnt[h]] = insn;
        pc_cnt[h]++;
        if (op != OP_SW && op != OP_ECALL && rd != 0) begin
            model_regs[h][rd] = res;
            e.rd   = rd[4:0];
            e.data = res;
            exp_q[h].push_back(e);
        end
    endtask

    task automatic build_programs();
        int rd;
        for (int h = 0; h < NUM_HARTS; h++) begin
            pc_cnt[h] = 0;
            for (int r = 0; r < NUM_REGS; r++)
                model_regs[h][r] = '0;
            put_insn(h, OP_ADDI, 5, 0, 0, (rand_bits(10) << 2) | h);   // Same rd, own value
            for (int r = 1; r <= 4; r++)
                put_insn(h, OP_ADDI, r, 0, 0, rand_bits(12));
            for (int n = 0; n < 12; n++) begin
                rd = rand_bits(3);                       // x0 target is dropped
                put_insn(h, ALU_OPS[rand_bits(3) % 6], rd, rand_bits(3), rand_bits(3),
                         rand_bits(12));
            end
            put_insn(h, OP_ADDI, 8, 0, 0, 32'h800 + h * 256);   // Wraps to 0x800 + h*0x100
            put_insn(h, OP_SW, 0, 8, 5, 0);
            put_insn(h, OP_SW, 0, 8, 6, 4);
            put_insn(h, OP_LW, 9, 8, 0, 0);
            put_insn(h, OP_LW, 10, 8, 0, 4);
            put_insn(h, OP_ECALL, 0, 0, 0, 0);
        end
    endtask

    ////////////////////
    // AXI4-Lite host
    ////////////////////
    task automatic host_write(input logic [15:0] addr, input word_t data,
                              input logic [1:0] exp_resp);
        logic aw_hit, w_hit, aw_done, w_done;
        @(negedge i_clk);
        i_awaddr  = addr;
        i_wdata   = data;
        i_awvalid = 1'b1;
        i_wvalid  = 1'b1;
        aw_done   = 1'b0;
        w_done    = 1'b0;
        while (!(aw_done && w_done)) begin
            aw_hit = i_awvalid && o_awready;             // Taken at the coming edge
            w_hit  = i_wvalid && o_wready;
            @(negedge i_clk);
            if (aw_hit) begin
                i_awvalid = 1'b0;
                aw_done   = 1'b1;
            end
            if (w_hit) begin
                i_wvalid = 1'b0;
                w_done   = 1'b1;
            end
        end
        while (!o_bvalid) @(negedge i_clk);
        checks++;
        a_bresp: assert (o_bresp == exp_resp) else begin
            errors++;
            $display("[ERROR] %0t o_bresp @%h: expected %0d, got %0d",
                     $time, addr, exp_resp, o_bresp);
        end
        @(negedge i_clk);                                // Response held one extra cycle
        i_bready = 1'b1;
        @(negedge i_clk);
        i_bready = 1'b0;
    endtask

    task automatic axil_read(input logic [15:0] addr, input word_t exp_data,
                             input logic [1:0] exp_resp);
        logic ar_hit;
        @(negedge i_clk);
        i_araddr  = addr;
        i_arvalid = 1'b1;
        ar_hit    = 1'b0;
        while (!ar_hit) begin
            ar_hit = o_arready;
            @(negedge i_clk);
        end
        i_arvalid = 1'b0;
        while (!o_rvalid) @(negedge i_clk);
        checks += 2;
        a_rresp: assert (o_rresp == exp_resp) else begin
            errors++;
            $display("[ERROR] %0t o_rresp @%h: expected %0d, got %0d",
                     $time, addr, exp_resp, o_rresp);
        end
        a_rdata: assert (o_rdata == exp_data) else begin
            errors++;
            $display("[ERROR] %0t o_rdata @%h: expected %h, got %h",
                     $time, addr, exp_data, o_rdata);
        end
    endtask

    ////////////////////
    // Checkers
    ////////////////////
    always @(negedge i_clk) begin : wb_check
        exp_wb_t e;
        if (i_arst_n && o_wb.we) begin
            checks++;
            if (exp_q[o_wb.hid].size() == 0) begin
                errors++;
                $display("Unexpected write-back from hart %0d to x%0d", o_wb.hid, o_wb.rd);
            end else begin
                e = exp_q[o_wb.hid].pop_front();
                a_wb_rd: assert (o_wb.rd == e.rd) else begin
                    errors++;
                    $display("[ERROR] %0t o_wb.rd hart %0d: expected %0d, got %0d",
                             $time, o_wb.hid, e.rd, o_wb.rd);
                end
                a_wb_data: assert (o_wb.data == e.data) else begin
                    errors++;
                    $display("[ERROR] %0t o_wb.data hart %0d x%0d: expected %h, got %h",
                             $time, o_wb.hid, e.rd, e.data, o_wb.data);
                end
            end
        end
    end

    // Halted hart never writes back
    a_wb_live_hart: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_wb.we |-> dut_i.active_mask[o_wb.hid])
        else begin
            errors++;
            $display("Write-back seen from halted hart %0d", $sampled(o_wb.hid));
        end

    a_b_backpressure: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_bvalid |-> !o_awready && !o_wready)
        else begin
            errors++;
            $display("AW or W accepted while a write response was pending");
        end

    a_r_backpressure: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_rvalid |-> !o_arready)
        else begin
            errors++;
            $display("AR accepted while a read response was pending");
        end

    initial begin : main
        word_t       d;
        logic [15:0] a;
        i_arst_n  = 1'b0;
        i_awaddr  = '0;
        i_awvalid = 1'b0;
        i_wdata   = '0;
        i_wvalid  = 1'b0;
        i_araddr  = '0;
        i_arvalid = 1'b0;
        i_bready  = 1'b0;                                // Raised per write response
        i_rready  = 1'b1;                                // Read data taken at once
        repeat (10) @(posedge i_clk);
        @(negedge i_clk);
        i_arst_n = 1'b1;

        // Random words in, then back out while idle
        for (int i = 0; i < 16; i++) begin
            a = 16'(16'h0C00 + i * 4);
            d = rand_bits(32);
            model_mem[a[11:2]] = d;
            host_write(a, d, OKAY);
        end
        for (int i = 0; i < 16; i++) begin
            a = 16'(16'h0C00 + i * 4);
            axil_read(a, model_mem[a[11:2]], OKAY);
        end

        build_programs();
        for (int h = 0; h < NUM_HARTS; h++) begin
            for (int n = 0; n < pc_cnt[h]; n++)
                host_write(16'(h * HART_CODE_WORDS * 4 + n * 4),
                           prog[h * HART_CODE_WORDS + n], OKAY);
        end
        d = rand_bits(32);
        model_mem[10'h3C0] = d;                          // Sentinel at 0xF00
        host_write(16'h0F00, d, OKAY);

        // Start, then hit the SPM while harts run
        host_write(16'h1000, 32'd1, OKAY);
        host_write(16'h0F00, ~d, SLVERR);
        host_write(16'h2000, d, SLVERR);                 // Unmapped
        checks++;
        a_run_started: assert (!o_all_idle) else begin
            errors++;
            $display("Harts were not running after the CTRL write");
        end
        while (!o_all_idle) @(negedge i_clk);
        for (int h = 0; h < NUM_HARTS; h++) begin
            checks++;
            a_wb_drained: assert (exp_q[h].size() == 0) else begin
                errors++;
                $display("Hart %0d halted with %0d write-backs missing", h, exp_q[h].size());
            end
        end
        axil_read(16'h1004, 32'h0000_0010, OKAY);        // All-idle, empty mask
        for (int h = 0; h < NUM_HARTS; h++) begin
            a = 16'(16'h0800 + h * 256);
            axil_read(a, model_mem[a[11:2]], OKAY);
            axil_read(a + 16'd4, model_mem[a[11:2] + 10'd1], OKAY);
        end
        axil_read(16'h0F00, model_mem[10'h3C0], OKAY);   // Untouched by the blocked write

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== fmrt_core_top.sv ====
`timescale 1ns/100ps

module fmrt_core_top (
    input  logic                              i_clk,
    input  logic                              i_arst_n,
    input  logic [fmrt_pkg::AXI_ADDR_W-1:0]   i_awaddr,
    input  logic                              i_awvalid,
    output logic                              o_awready,
    input  fmrt_pkg::word_t                   i_wdata,
    input  logic                              i_wvalid,
    output logic                              o_wready,
    output logic [1:0]                        o_bresp,
    output logic                              o_bvalid,
    input  logic                              i_bready,
    input  logic [fmrt_pkg::AXI_ADDR_W-1:0]   i_araddr,
    input  logic                              i_arvalid,
    output logic                              o_arready,
    output fmrt_pkg::word_t                   o_rdata,
    output logic [1:0]                        o_rresp,
    output logic                              o_rvalid,
    input  logic                              i_rready,
    output fmrt_pkg::wb_t                     o_wb,          // Write-back, also into GPR
    output logic                              o_all_idle
);
    import fmrt_pkg::*;

    spm_req_t               host_req, mem_req;   // Port B requesters
    spm_addr_t              fetch_addr;
    word_t                  fetch_data, b_rdata;
    if_id_t                 if_id;
    id_ex_t                 id_ex;
    ex_mem_t                ex_mem;
    reg_addr_t              rs1_addr, rs2_addr;
    hart_id_t               rd_hid, halt_hid;
    word_t                  rs1_data, rs2_data;
    logic                   halt, run_pulse;
    logic [NUM_HARTS-1:0]   active_mask;

    ////////////////////
    // Host side
    ////////////////////
    axil_host_port host_i (
        .i_clk(i_clk), .i_arst_n(i_arst_n),
        .i_awaddr(i_awaddr), .i_awvalid(i_awvalid), .o_awready(o_awready),
        .i_wdata(i_wdata), .i_wvalid(i_wvalid), .o_wready(o_wready),
        .o_bresp(o_bresp), .o_bvalid(o_bvalid), .i_bready(i_bready),
        .i_araddr(i_araddr), .i_arvalid(i_arvalid), .o_arready(o_arready),
        .o_rdata(o_rdata), .o_rresp(o_rresp), .o_rvalid(o_rvalid), .i_rready(i_rready),
        .i_active_mask(active_mask), .o_run_pulse(run_pulse),
        .o_host_req(host_req), .i_host_rdata(b_rdata)
    );

    spm spm_i (
        .i_clk(i_clk),
        .i_fetch_addr(fetch_addr), .o_fetch_data(fetch_data),
        .i_mem_req(mem_req), .i_host_req(host_req), .o_b_rdata(b_rdata)
    );

    ////////////////////
    // Pipeline
    ////////////////////
    if_stage if_i (
        .i_clk(i_clk), .i_arst_n(i_arst_n),
        .i_run_pulse(run_pulse), .i_halt(halt), .i_halt_hid(halt_hid),
        .o_fetch_addr(fetch_addr), .i_fetch_data(fetch_data),
        .o_if_id(if_id), .o_active_mask(active_mask), .o_all_idle(o_all_idle)
    );

    id_stage id_i (
        .i_clk(i_clk), .i_arst_n(i_arst_n), .i_if_id(if_id),
        .o_rs1_addr(rs1_addr), .o_rs2_addr(rs2_addr), .o_rd_hid(rd_hid),
        .i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
        .o_id_ex(id_ex), .o_halt(halt), .o_halt_hid(halt_hid)
    );

    gpr gpr_i (
        .i_clk(i_clk), .i_arst_n(i_arst_n), .i_rd_hid(rd_hid),
        .i_rs1_addr(rs1_addr), .i_rs2_addr(rs2_addr),
        .o_rs1_data(rs1_data), .o_rs2_data(rs2_data), .i_wb(o_wb)
    );

    ex_stage ex_i (
        .i_clk(i_clk), .i_arst_n(i_arst_n), .i_id_ex(id_ex), .o_ex_mem(ex_mem)
    );

    mem_stage mem_i (
        .i_ex_mem(ex_mem), .o_mem_req(mem_req), .i_b_rdata(b_rdata), .o_wb(o_wb)
    );

endmodule

// ==== mem_stage.sv ====
`timescale 1ns/100ps

module mem_stage (
    input  fmrt_pkg::ex_mem_t   i_ex_mem,
    output fmrt_pkg::spm_req_t  o_mem_req,     // To SPM port B
    input  fmrt_pkg::word_t     i_b_rdata,
    output fmrt_pkg::wb_t       o_wb
);
    import fmrt_pkg::*;

    logic is_mem, is_alu;

    assign is_mem = i_ex_mem.valid && (i_ex_mem.op == OP_LW || i_ex_mem.op == OP_SW);
    assign is_alu = i_ex_mem.valid && (i_ex_mem.op inside {OP_ADDI, OP_ADD, OP_SUB,
                                                           OP_AND, OP_OR, OP_XOR});

    assign o_mem_req = '{valid: is_mem,
                         write: (i_ex_mem.op == OP_SW),
                         addr:  i_ex_mem.result[SPM_ADDR_W+1:2],   // Byte to word
                         wdata: i_ex_mem.sdata};

    // Load data or ALU result, no write to x0
    assign o_wb = '{we:   (is_alu || (is_mem && i_ex_mem.op == OP_LW)) && i_ex_mem.rd != '0,
                    hid:  i_ex_mem.hid,
                    rd:   i_ex_mem.rd,
                    data: (i_ex_mem.op == OP_LW) ? i_b_rdata : i_ex_mem.result};

    always_comb begin
        if (is_mem)
            a_word_aligned: assert (i_ex_mem.result[1:0] == 2'b00)
                else $error("misaligned LW/SW address %h", i_ex_mem.result);
    end

endmodule

// ==== ex_stage.sv ====
`timescale 1ns/100ps

module ex_stage (
    input  logic               i_clk,
    input  logic               i_arst_n,
    input  fmrt_pkg::id_ex_t   i_id_ex,
    output fmrt_pkg::ex_mem_t  o_ex_mem
);
    import fmrt_pkg::*;

    word_t result;

    always_comb begin
        case (i_id_ex.op)
            OP_ADD:               result = i_id_ex.opa + i_id_ex.opb;
            OP_SUB:               result = i_id_ex.opa - i_id_ex.opb;
            OP_AND:               result = i_id_ex.opa & i_id_ex.opb;
            OP_OR:                result = i_id_ex.opa | i_id_ex.opb;
            OP_XOR:               result = i_id_ex.opa ^ i_id_ex.opb;
            OP_ADDI, OP_LW, OP_SW: result = i_id_ex.opa + i_id_ex.imm;   // Byte addr for mem
            default:              result = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n)
            o_ex_mem <= '0;
        else
            o_ex_mem <= '{valid: i_id_ex.valid, hid: i_id_ex.hid, op: i_id_ex.op,
                          rd: i_id_ex.rd, result: result, sdata: i_id_ex.sdata};
    end

endmodule

// ==== gpr.sv ====
`timescale 1ns/100ps

module gpr (
    input  logic                 i_clk,
    input  logic                 i_arst_n,
    input  fmrt_pkg::hart_id_t   i_rd_hid,      // Reading hart, from ID
    input  fmrt_pkg::reg_addr_t  i_rs1_addr,
    input  fmrt_pkg::reg_addr_t  i_rs2_addr,
    output fmrt_pkg::word_t      o_rs1_data,
    output fmrt_pkg::word_t      o_rs2_data,
    input  fmrt_pkg::wb_t        i_wb           // Writing hart, from MEM
);
    import fmrt_pkg::*;

    word_t regs_q [NUM_HARTS][NUM_REGS];          // One bank per hart

    assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs_q[i_rd_hid][i_rs1_addr];
    assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs_q[i_rd_hid][i_rs2_addr];

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int h = 0; h < NUM_HARTS; h++) begin
                for (int r = 0; r < NUM_REGS; r++) begin
                    regs_q[h][r] <= '0;
                end
            end
        end else if (i_wb.we && i_wb.rd != '0) begin
            regs_q[i_wb.hid][i_wb.rd] <= i_wb.data;   // Seen by ID next cycle
        end
    end

    a_no_x0_write: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_wb.we |-> (i_wb.rd != '0));

endmodule

// ==== id_stage.sv ====
`timescale 1ns/100ps

module id_stage (
    input  logic                 i_clk,
    input  logic                 i_arst_n,
    input  fmrt_pkg::if_id_t     i_if_id,
    output fmrt_pkg::reg_addr_t  o_rs1_addr,
    output fmrt_pkg::reg_addr_t  o_rs2_addr,
    output fmrt_pkg::hart_id_t   o_rd_hid,      // Bank select for reads
    input  fmrt_pkg::word_t      i_rs1_data,
    input  fmrt_pkg::word_t      i_rs2_data,
    output fmrt_pkg::id_ex_t     o_id_ex,
    output logic                 o_halt,
    output fmrt_pkg::hart_id_t   o_halt_hid
);
    import fmrt_pkg::*;

    word_t      insn;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    op_e        op;
    word_t      imm;

    assign insn       = i_if_id.insn;
    assign opcode     = insn[6:0];
    assign funct3     = insn[14:12];
    assign funct7     = insn[31:25];
    assign o_rs1_addr = insn[19:15];
    assign o_rs2_addr = insn[24:20];
    assign o_rd_hid   = i_if_id.hid;

    ////////////////////
    // Opcode decode
    ////////////////////
    always_comb begin
        op = OP_NOP;                                 // Anything else is a no-op
        case (opcode)
            OPC_OP_IMM: if (funct3 == 3'b000) op = OP_ADDI;
            OPC_OP: begin
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000:  op = OP_ADD;
                        3'b100:  op = OP_XOR;
                        3'b110:  op = OP_OR;
                        3'b111:  op = OP_AND;
                        default: op = OP_NOP;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    op = OP_SUB;
                end
            end
            OPC_LOAD:   if (funct3 == 3'b010) op = OP_LW;
            OPC_STORE:  if (funct3 == 3'b010) op = OP_SW;
            OPC_SYSTEM: if (insn == INSN_ECALL) op = OP_ECALL;
            default:    op = OP_NOP;
        endcase
        if (!i_if_id.valid)
            op = OP_NOP;                             // Bubble
    end

    // S-type for stores, I-type otherwise
    assign imm = (op == OP_SW) ? {{20{insn[31]}}, insn[31:25], insn[11:7]}
                               : {{20{insn[31]}}, insn[31:20]};

    assign o_halt     = (op == OP_ECALL);            // Parks the hart
    assign o_halt_hid = i_if_id.hid;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n)
            o_id_ex <= '0;
        else
            o_id_ex <= '{valid: i_if_id.valid, hid: i_if_id.hid, op: op,
                         rd: insn[11:7], opa: i_rs1_data, opb: i_rs2_data,
                         imm: imm, sdata: i_rs2_data};
    end

endmodule

// ==== if_stage.sv ====
`timescale 1ns/100ps

module if_stage (
    input  logic                              i_clk,
    input  logic                              i_arst_n,
    input  logic                              i_run_pulse,
    input  logic                              i_halt,          // ECALL seen in ID
    input  fmrt_pkg::hart_id_t                i_halt_hid,
    output fmrt_pkg::spm_addr_t               o_fetch_addr,
    input  fmrt_pkg::word_t                   i_fetch_data,
    output fmrt_pkg::if_id_t                  o_if_id,
    output logic [fmrt_pkg::NUM_HARTS-1:0]    o_active_mask,
    output logic                              o_all_idle
);
    import fmrt_pkg::*;

    hart_id_t    issue_q;                 // Round-robin slot owner
    word_t       pc_q [NUM_HARTS];
    hart_state_e state_q [NUM_HARTS];
    logic        slot_act;                // Owner may issue
    logic        valid_q;
    hart_id_t    hid_q;
    word_t       pc_id_q;                 // PC of the word in flight

    assign slot_act     = (state_q[issue_q] == HS_ACTIVE);
    assign o_fetch_addr = pc_q[issue_q][SPM_ADDR_W+1:2];

    always_comb begin
        for (int h = 0; h < NUM_HARTS; h++) begin
            o_active_mask[h] = (state_q[h] == HS_ACTIVE);
        end
    end
    assign o_all_idle = ~|o_active_mask;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            issue_q <= '0;
            valid_q <= 1'b0;
            for (int h = 0; h < NUM_HARTS; h++) begin
                state_q[h] <= HS_IDLE;
                pc_q[h]    <= '0;
            end
        end else begin
            issue_q <= issue_q + 1'b1;               // Rotates every cycle
            valid_q <= slot_act;                     // Idle slot is a bubble
            if (i_run_pulse && o_all_idle) begin
                for (int h = 0; h < NUM_HARTS; h++) begin
                    state_q[h] <= HS_ACTIVE;
                    pc_q[h]    <= word_t'(h * HART_CODE_WORDS * 4);   // Own code base
                end
            end else begin
                if (slot_act)
                    pc_q[issue_q] <= pc_q[issue_q] + 32'd4;
                if (i_halt)
                    state_q[i_halt_hid] <= HS_IDLE;  // Lands before its next slot
            end
        end
    end

    always_ff @(posedge i_clk) begin
        hid_q   <= issue_q;
        pc_id_q <= pc_q[issue_q];
    end

    assign o_if_id = '{valid: valid_q, hid: hid_q, pc: pc_id_q, insn: i_fetch_data};

endmodule

// ==== axil_host_port.sv ====
`timescale 1ns/100ps

module axil_host_port (
    input  logic                              i_clk,
    input  logic                              i_arst_n,
    input  logic [fmrt_pkg::AXI_ADDR_W-1:0]   i_awaddr,
    input  logic                              i_awvalid,
    output logic                              o_awready,
    input  fmrt_pkg::word_t                   i_wdata,
    input  logic                              i_wvalid,
    output logic                              o_wready,
    output logic [1:0]                        o_bresp,
    output logic                              o_bvalid,
    input  logic                              i_bready,
    input  logic [fmrt_pkg::AXI_ADDR_W-1:0]   i_araddr,
    input  logic                              i_arvalid,
    output logic                              o_arready,
    output fmrt_pkg::word_t                   o_rdata,
    output logic [1:0]                        o_rresp,
    output logic                              o_rvalid,
    input  logic                              i_rready,
    input  logic [fmrt_pkg::NUM_HARTS-1:0]    i_active_mask,
    output logic                              o_run_pulse,   // One cycle, starts all harts
    output fmrt_pkg::spm_req_t                o_host_req,
    input  fmrt_pkg::word_t                   i_host_rdata
);
    import fmrt_pkg::*;

    logic [AXI_ADDR_W-1:0] awaddr_q, araddr_q;
    word_t                 wdata_q;
    logic                  aw_full_q, w_full_q, ar_full_q;   // Channel captured
    logic                  all_idle, wr_go, rd_go;
    logic                  wr_spm, wr_ctrl, wr_ok;
    logic                  rd_spm, rd_stat, rd_ok;

    assign all_idle = ~|i_active_mask;
    assign wr_go    = aw_full_q && w_full_q;                 // Both halves in hand
    assign rd_go    = ar_full_q && !wr_go;                   // Write wins port B

    // Address decode, SPM is the low 4 KiB
    assign wr_spm  = (awaddr_q[AXI_ADDR_W-1:SPM_ADDR_W+2] == '0);
    assign wr_ctrl = (awaddr_q == CTRL_ADDR);
    assign wr_ok   = (wr_spm && all_idle) || wr_ctrl || (awaddr_q == STATUS_ADDR);
    assign rd_spm  = (araddr_q[AXI_ADDR_W-1:SPM_ADDR_W+2] == '0);
    assign rd_stat = (araddr_q == STATUS_ADDR);
    assign rd_ok   = (rd_spm && all_idle) || rd_stat || (araddr_q == CTRL_ADDR);

    // Back-pressure while a response is pending
    assign o_awready = !aw_full_q && !o_bvalid;
    assign o_wready  = !w_full_q && !o_bvalid;
    assign o_arready = !ar_full_q && !o_rvalid;

    always_comb begin
        o_host_req = '0;
        if (wr_go) begin
            o_host_req.valid = wr_spm && all_idle;   // Blocked while running
            o_host_req.write = 1'b1;
            o_host_req.addr  = awaddr_q[SPM_ADDR_W+1:2];
            o_host_req.wdata = wdata_q;
        end else if (rd_go) begin
            o_host_req.valid = rd_spm && all_idle;
            o_host_req.addr  = araddr_q[SPM_ADDR_W+1:2];
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            aw_full_q   <= 1'b0;
            w_full_q    <= 1'b0;
            ar_full_q   <= 1'b0;
            o_bvalid    <= 1'b0;
            o_rvalid    <= 1'b0;
            o_run_pulse <= 1'b0;
        end else begin
            o_run_pulse <= wr_go && wr_ctrl && wdata_q[0] && all_idle;
            if (o_awready && i_awvalid) aw_full_q <= 1'b1;
            if (o_wready && i_wvalid)   w_full_q  <= 1'b1;
            if (o_arready && i_arvalid) ar_full_q <= 1'b1;
            if (wr_go) begin
                aw_full_q <= 1'b0;
                w_full_q  <= 1'b0;
                o_bvalid  <= 1'b1;
            end else if (i_bready) begin
                o_bvalid  <= 1'b0;
            end
            if (rd_go) begin
                ar_full_q <= 1'b0;
                o_rvalid  <= 1'b1;                   // Two cycles after AR
            end else if (i_rready) begin
                o_rvalid  <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_awready && i_awvalid) awaddr_q <= i_awaddr;
        if (o_wready && i_wvalid)   wdata_q  <= i_wdata;
        if (o_arready && i_arvalid) araddr_q <= i_araddr;
        if (wr_go) o_bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
        if (rd_go) begin
            o_rresp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
            if (rd_stat)
                o_rdata <= {{(XLEN-NUM_HARTS-1){1'b0}}, all_idle, i_active_mask};
            else if (rd_spm && all_idle)
                o_rdata <= i_host_rdata;
            else
                o_rdata <= '0;
        end
    end

    a_bvalid_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_bvalid && !i_bready |=> o_bvalid && $stable(o_bresp));

endmodule

// ==== spm.sv ====
`timescale 1ns/100ps

module spm (
    input  logic                 i_clk,
    input  fmrt_pkg::spm_addr_t  i_fetch_addr,   // Port A, fetch
    output fmrt_pkg::word_t      o_fetch_data,
    input  fmrt_pkg::spm_req_t   i_mem_req,      // Port B, load/store
    input  fmrt_pkg::spm_req_t   i_host_req,     // Port B, host while idle
    output fmrt_pkg::word_t      o_b_rdata
);
    import fmrt_pkg::*;

    word_t    mem_q [SPM_WORDS];
    spm_req_t b_req;

    assign b_req = i_mem_req.valid ? i_mem_req : i_host_req;   // Pipeline first

    always_ff @(posedge i_clk) begin
        o_fetch_data <= mem_q[i_fetch_addr];                   // Instr one cycle later
        if (b_req.valid && b_req.write)
            mem_q[b_req.addr] <= b_req.wdata;
    end

    // Port B reads through so a load completes in its MEM cycle
    assign o_b_rdata = mem_q[b_req.addr];

    a_portb_excl: assert property (@(posedge i_clk)
        !(i_mem_req.valid && i_host_req.valid));

endmodule

// ==== fmrt_pkg.sv ====
package fmrt_pkg;

    ////////////////////
    // Core sizing
    ////////////////////
    localparam int XLEN            = 32;     // Data word width
    localparam int NUM_HARTS       = 4;      // Must equal pipeline depth
    localparam int HART_ID_W       = 2;
    localparam int SPM_WORDS       = 1024;
    localparam int SPM_ADDR_W      = 10;     // Word address bits
    localparam int HART_CODE_WORDS = 128;    // Code region per hart
    localparam int REG_ADDR_W      = 5;
    localparam int NUM_REGS        = 32;     // GPRs per hart

    ////////////////////
    // Host port
    ////////////////////
    localparam int               AXI_ADDR_W  = 16;
    localparam logic [15:0]      CTRL_ADDR   = 16'h1000;  // Bit 0 starts a run
    localparam logic [15:0]      STATUS_ADDR = 16'h1004;  // Active mask, all-idle
    localparam logic [1:0]       RESP_OKAY   = 2'b00;
    localparam logic [1:0]       RESP_SLVERR = 2'b10;

    ////////////////////
    // RV32I encodings
    ////////////////////
    localparam logic [6:0]  OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0]  OPC_OP     = 7'b0110011;
    localparam logic [6:0]  OPC_LOAD   = 7'b0000011;
    localparam logic [6:0]  OPC_STORE  = 7'b0100011;
    localparam logic [6:0]  OPC_SYSTEM = 7'b1110011;
    localparam logic [31:0] INSN_ECALL = 32'h0000_0073;

    typedef logic [HART_ID_W-1:0]  hart_id_t;
    typedef logic [XLEN-1:0]       word_t;
    typedef logic [SPM_ADDR_W-1:0] spm_addr_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        OP_NOP, OP_ADDI, OP_ADD, OP_SUB, OP_AND,
        OP_OR, OP_XOR, OP_LW, OP_SW, OP_ECALL
    } op_e;

    typedef enum logic {HS_IDLE, HS_ACTIVE} hart_state_e;

    typedef struct packed {
        logic      valid;
        hart_id_t  hid;
        word_t     pc;
        word_t     insn;
    } if_id_t;

    typedef struct packed {
        logic      valid;
        hart_id_t  hid;
        op_e       op;
        reg_addr_t rd;
        word_t     opa;      // rs1 value
        word_t     opb;      // rs2 value
        word_t     imm;      // I or S immediate
        word_t     sdata;    // Store data
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        hart_id_t  hid;
        op_e       op;
        reg_addr_t rd;
        word_t     result;   // ALU result or byte address
        word_t     sdata;
    } ex_mem_t;

    typedef struct packed {
        logic      we;
        hart_id_t  hid;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

    typedef struct packed {
        logic      valid;
        logic      write;
        spm_addr_t addr;
        word_t     wdata;
    } spm_req_t;

endpackage
